/* src/ulaPkg.sv */
package ulaPkg;

  //////////////////////////////////////////////////
  // Sequencer strobes, one clock wide
  //////////////////////////////////////////////////
  typedef struct packed {
    logic phiEn;        // Slot 15, system cycle enable
    logic fetch1Latch;  // Slot 23
    logic fetch2Latch;  // Slot 7
    logic busLatch;     // Slots 2 and 10
    logic attribDecode; // Slot 3
    logic pixelEn;      // Six per system cycle
    logic reload;       // Slot 17
  } seqStrobes_t;

  // Thirds of the 1 MHz cycle
  typedef enum logic [1:0] {
    phVideo1,
    phVideo2,
    phCpu     // Idle here, keeps PHI2 shape
  } phase_e;

  typedef struct packed {
    logic [6:0] hCount;
    logic [8:0] vCount;
    logic       hBlankN;    // Registered on pixelEn
    logic       vBlankN;    // Registered on pixelEn
    logic       forceText;  // Below the hires area
    logic       lineReload; // Attribute reset window
  } videoPos_t;

  // Selected by attribute bits 6..3
  typedef enum logic [3:0] {
    arInk   = 4'd0,
    arStyle = 4'd1,
    arPaper = 4'd2,
    arMode  = 4'd3
  } attrReg_e;

  typedef struct packed {
    logic [2:0] ink;
    logic [2:0] paper;
    logic       altSet;    // Style bit 0
    logic       dblHeight; // Style bit 1
    logic       freq50;    // Mode bit 1
    logic       hires;     // Mode bit 2
  } attrState_t;

  //////////////////////////////////////////////////
  // Fixed video constants
  //////////////////////////////////////////////////
  localparam logic [6:0] hLast       = 7'd63;
  localparam logic [6:0] hSyncFirst  = 7'd49;
  localparam logic [6:0] hSyncLast   = 7'd53;
  localparam logic [6:0] charsPerRow = 7'd40;
  localparam logic [6:0] hVisFirst   = 7'd1;
  localparam logic [6:0] hVisLast    = hVisFirst + charsPerRow - 7'd1; // Column 40

  localparam logic [8:0] vBlankFirst  = 9'd224;
  localparam logic [8:0] textLastLine = 9'd199;
  localparam logic [8:0] vSync50First = 9'd258;
  localparam logic [8:0] vSync60First = 9'd241;
  localparam logic [8:0] vSyncLines   = 9'd2;

  // Charset prefixes, address bits 15..10
  localparam logic [5:0] textStdPrefix  = 6'h2D;
  localparam logic [5:0] textAltPrefix  = 6'h2E;
  localparam logic [5:0] hiresStdPrefix = 6'h26;
  localparam logic [5:0] hiresAltPrefix = 6'h27;

endpackage

/* src/ulaSequencer.sv */
`timescale 1ns/1ns

module ulaSequencer (
  input  logic                CLK_24,
  input  logic                RESET_INT,
  output ulaPkg::seqStrobes_t strobes,
  output ulaPkg::phase_e      phase
);

  logic [23:0] ring; // One hot, bit n is slot n
  logic        phaseStep;

  // Phase moves on at the end of each 8-slot third
  assign phaseStep = ring[7] | ring[15] | ring[23];

  //////////////////////////////////////////////////
  // Slot ring and phase
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      ring  <= 24'd1;            // Slot 0
      phase <= ulaPkg::phVideo1;
    end else begin
      ring <= {ring[22:0], ring[23]}; // Rotate every clock
      if (phaseStep) begin
        case (phase)
          ulaPkg::phVideo1: phase <= ulaPkg::phVideo2;
          ulaPkg::phVideo2: phase <= ulaPkg::phCpu;
          default:          phase <= ulaPkg::phVideo1;
        endcase
      end
    end
  end

  // Slot decode
  always_comb begin
    strobes.phiEn        = ring[15];           // Just before PHI2 rises
    strobes.fetch1Latch  = ring[23];           // Phase 1 address out
    strobes.fetch2Latch  = ring[7];            // Phase 2 address out
    strobes.busLatch     = ring[2] | ring[10]; // Memory answers here
    strobes.attribDecode = ring[3];
    strobes.pixelEn      = ring[1] | ring[5] | ring[9] |
                           ring[13] | ring[17] | ring[21];
    strobes.reload       = ring[17];           // Shifter load pixel
  end

endmodule

/* src/videoTiming.sv */
`timescale 1ns/1ns

module videoTiming #(
  parameter int lastLine50 = 312,
  parameter int lastLine60 = 260
) (
  input  logic                CLK_24,
  input  logic                RESET_INT,
  input  ulaPkg::seqStrobes_t strobes,
  input  ulaPkg::attrState_t  attr,
  output ulaPkg::videoPos_t   pos,
  output logic                hSyncN,
  output logic                vSyncN
);

  logic [6:0] hCount;
  logic [8:0] vCount;
  logic [8:0] lastLine;   // Last line for current rate
  logic [8:0] vSyncFirst;
  logic       hVisible;
  logic       vVisible;
  logic       hBlankNReg;
  logic       vBlankNReg;

  // Frame length follows the mode register
  assign lastLine   = attr.freq50 ? 9'(lastLine50) : 9'(lastLine60);
  assign vSyncFirst = attr.freq50 ? ulaPkg::vSync50First : ulaPkg::vSync60First;

  //////////////////////////////////////////////////
  // Line and frame counters
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      hCount <= '0;
      vCount <= '0;
    end else if (strobes.phiEn) begin
      if (hCount == ulaPkg::hLast) begin
        hCount <= '0;
        // Line done, step or wrap the frame
        if (vCount == lastLine)
          vCount <= '0;
        else
          vCount <= vCount + 9'd1;
      end else begin
        hCount <= hCount + 7'd1;
      end
    end
  end

  assign hVisible = (hCount >= ulaPkg::hVisFirst) && (hCount <= ulaPkg::hVisLast);
  assign vVisible = vCount < ulaPkg::vBlankFirst;

  // Blanking held per pixel
  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      hBlankNReg <= 1'b0;
      vBlankNReg <= 1'b0;
    end else if (strobes.pixelEn) begin
      hBlankNReg <= hVisible;
      vBlankNReg <= vVisible;
    end
  end

  // Syncs, straight from the counters
  assign hSyncN = ~((hCount >= ulaPkg::hSyncFirst) && (hCount <= ulaPkg::hSyncLast));
  assign vSyncN = ~((vCount >= vSyncFirst) &&
                    (vCount < vSyncFirst + ulaPkg::vSyncLines)); // Two lines

  always_comb begin
    pos.hCount     = hCount;
    pos.vCount     = vCount;
    pos.hBlankN    = hBlankNReg;
    pos.vBlankN    = vBlankNReg;
    pos.forceText  = vCount > ulaPkg::textLastLine;   // Bottom rows stay text
    pos.lineReload = hCount >= ulaPkg::hSyncFirst;    // From hsync to line end
  end

endmodule

/* src/videoAddrGen.sv */
`timescale 1ns/1ns

module videoAddrGen #(
  parameter logic [15:0] textBase  = 16'hBB80,
  parameter logic [15:0] hiresBase = 16'hA000
) (
  input  logic                CLK_24,
  input  ulaPkg::seqStrobes_t strobes,
  input  ulaPkg::videoPos_t   pos,
  input  ulaPkg::attrState_t  attr,
  input  logic [6:0]          fetchByte,
  input  logic                hiresActive,
  output logic [15:0]         memAddr
);

  logic [8:0]  rowIndex;   // Screen row
  logic [15:0] rowOffset;  // Row times 40
  logic [15:0] screenBase;
  logic [15:0] addrPh1;
  logic [5:0]  charPrefix;
  logic        dblEn;
  logic [2:0]  charRow;
  logic [15:0] addrPh2;

  //////////////////////////////////////////////////
  // Phase 1, screen byte
  //////////////////////////////////////////////////
  assign rowIndex   = hiresActive ? pos.vCount : {3'b000, pos.vCount[8:3]}; // Text rows of 8
  // 32x plus 8x
  assign rowOffset  = {2'b00, rowIndex, 5'b00000} + {4'b0000, rowIndex, 3'b000};
  assign screenBase = hiresActive ? hiresBase : textBase;
  assign addrPh1    = screenBase + rowOffset + {9'd0, pos.hCount};

  //////////////////////////////////////////////////
  // Phase 2, pattern byte
  //////////////////////////////////////////////////
  always_comb begin
    case ({attr.hires, attr.altSet})
      2'b11:   charPrefix = ulaPkg::hiresAltPrefix;
      2'b10:   charPrefix = ulaPkg::hiresStdPrefix;
      2'b01:   charPrefix = ulaPkg::textAltPrefix;
      default: charPrefix = ulaPkg::textStdPrefix;
    endcase
  end

  assign dblEn   = attr.dblHeight & ~hiresActive;           // No double height in hires
  assign charRow = dblEn ? pos.vCount[3:1] : pos.vCount[2:0];
  assign addrPh2 = {charPrefix, fetchByte, charRow};

  // Address held between fetch strobes
  always_ff @(posedge CLK_24) begin
    if (strobes.fetch1Latch)
      memAddr <= addrPh1;
    else if (strobes.fetch2Latch)
      memAddr <= addrPh2;
  end

endmodule

/* src/attribLatch.sv */
`timescale 1ns/1ns

module attribLatch (
  input  logic                CLK_24,
  input  logic                RESET_INT,
  input  ulaPkg::seqStrobes_t strobes,
  input  ulaPkg::videoPos_t   pos,
  input  logic [7:0]          memData,
  output ulaPkg::attrState_t  attr,
  output logic [6:0]          fetchByte,
  output logic                isAttrib,
  output logic                hiresActive,
  output logic [5:0]          pattern,
  output logic                inverse
);

  logic [7:0] busData;   // Last byte off memory
  logic [8:0] decodeDly; // Bit n high in slot 4+n
  logic       slot5;
  logic       slot9;
  logic       slot12;
  logic       loadHold;
  logic [6:0] holdReg;
  logic       blankN;

  // Memory byte, phase 1 then phase 2
  always_ff @(posedge CLK_24) begin
    if (strobes.busLatch)
      busData <= memData;
  end

  // Attribute flag and inverse bit of the screen byte
  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      isAttrib <= 1'b0;
      inverse  <= 1'b0;
    end else if (strobes.attribDecode) begin
      isAttrib <= ~|busData[6:5]; // Bits 6..5 clear
      inverse  <= busData[7];
    end
  end

  //////////////////////////////////////////////////
  // Hold register load slots
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT)
      decodeDly <= '0;
    else
      decodeDly <= {decodeDly[7:0], strobes.attribDecode};
  end

  assign slot5  = decodeDly[1];
  assign slot9  = decodeDly[5];
  assign slot12 = decodeDly[8];

  assign hiresActive = attr.hires & ~pos.forceText;
  assign loadHold    = (~isAttrib & ~hiresActive & slot12) | // Text pattern, phase 2 byte
                       (~isAttrib &  hiresActive & slot5)  | // Hires pixels, phase 1 byte
                       ( isAttrib & slot9);                  // Attribute, phase 1 byte

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT)
      holdReg <= '0;
    else if (loadHold)
      holdReg <= busData[6:0];
  end

  //////////////////////////////////////////////////
  // Serial attribute registers
  //////////////////////////////////////////////////
  assign blankN = pos.hBlankN & pos.vBlankN;

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      attr <= '{ink: 3'd7, paper: 3'd0, altSet: 1'b0, dblHeight: 1'b0,
                freq50: 1'b0, hires: 1'b0};                          // 60 Hz text
    end else if (pos.lineReload) begin
      attr.ink       <= 3'd7; // White ink each line
      attr.paper     <= 3'd0;
      attr.altSet    <= 1'b0;
      attr.dblHeight <= 1'b0; // Mode survives
    end else if (strobes.reload && isAttrib && blankN) begin
      case (ulaPkg::attrReg_e'(holdReg[6:3]))
        ulaPkg::arInk:   attr.ink <= holdReg[2:0];
        ulaPkg::arStyle: {attr.dblHeight, attr.altSet} <= holdReg[1:0];
        ulaPkg::arPaper: attr.paper <= holdReg[2:0];
        ulaPkg::arMode:  {attr.hires, attr.freq50} <= holdReg[2:1];
        default: ;
      endcase
    end
  end

  assign fetchByte = busData[6:0]; // Character code for phase 2
  assign pattern   = holdReg[5:0];

endmodule

/* src/pixelShifter.sv */
`timescale 1ns/1ns

module pixelShifter (
  input  logic                CLK_24,
  input  ulaPkg::seqStrobes_t strobes,
  input  ulaPkg::attrState_t  attr,
  input  logic                isAttrib,
  input  logic [5:0]          pattern,
  input  logic                inverse,
  output logic [2:0]          rgb
);

  logic [5:0] shiftReg; // MSB is the current pixel
  logic       invReg;
  logic       loadCell;
  logic [2:0] colour;

  assign loadCell = strobes.pixelEn & strobes.reload;

  // Inverse changes with the cell
  always_ff @(posedge CLK_24) begin
    if (loadCell)
      invReg <= inverse;
  end

  always_ff @(posedge CLK_24) begin
    if (strobes.pixelEn) begin
      if (strobes.reload)
        shiftReg <= isAttrib ? 6'd0 : pattern; // Attribute cell is all paper
      else
        shiftReg <= {shiftReg[4:0], 1'b0};
    end
  end

  assign colour = shiftReg[5] ? attr.ink : attr.paper;
  assign rgb    = invReg ? ~colour : colour; // Red in bit 0

endmodule

/* src/ulaVideo.sv */
`timescale 1ns/1ns

module ulaVideo #(
  parameter int          lastLine50 = 312,
  parameter int          lastLine60 = 260,
  parameter logic [15:0] textBase   = 16'hBB80,
  parameter logic [15:0] hiresBase  = 16'hA000
) (
  input  logic        CLK_24,
  input  logic        RESET_INT,
  input  logic [7:0]  memData,
  output logic [15:0] memAddr,
  output logic        phi2,
  output logic        phi2En,
  output logic        pixClk,
  output logic [2:0]  rgb,
  output logic        hSyncN,
  output logic        vSyncN,
  output logic        hBlank,
  output logic        vBlank
);

  ulaPkg::seqStrobes_t strobes;
  ulaPkg::phase_e      phase;
  ulaPkg::videoPos_t   pos;
  ulaPkg::attrState_t  attr;
  logic [6:0]          fetchByte;
  logic                isAttrib;
  logic                hiresActive;
  logic [5:0]          pattern;
  logic                inverse;

  //////////////////////////////////////////////////
  // Producer, sequencer and counters
  //////////////////////////////////////////////////
  ulaSequencer seq0 (
    .CLK_24    (CLK_24),
    .RESET_INT (RESET_INT),
    .strobes   (strobes),
    .phase     (phase)
  );

  videoTiming #(
    .lastLine50 (lastLine50),
    .lastLine60 (lastLine60)
  ) timing0 (
    .CLK_24    (CLK_24),
    .RESET_INT (RESET_INT),
    .strobes   (strobes),
    .attr      (attr),
    .pos       (pos),
    .hSyncN    (hSyncN),
    .vSyncN    (vSyncN)
  );

  videoAddrGen #(
    .textBase  (textBase),
    .hiresBase (hiresBase)
  ) addr0 (
    .CLK_24      (CLK_24),
    .strobes     (strobes),
    .pos         (pos),
    .attr        (attr),
    .fetchByte   (fetchByte),
    .hiresActive (hiresActive),
    .memAddr     (memAddr)
  );

  // Buffer, fetched bytes and attributes
  attribLatch attrib0 (
    .CLK_24      (CLK_24),
    .RESET_INT   (RESET_INT),
    .strobes     (strobes),
    .pos         (pos),
    .memData     (memData),
    .attr        (attr),
    .fetchByte   (fetchByte),
    .isAttrib    (isAttrib),
    .hiresActive (hiresActive),
    .pattern     (pattern),
    .inverse     (inverse)
  );

  // Consumer
  pixelShifter shift0 (
    .CLK_24   (CLK_24),
    .strobes  (strobes),
    .attr     (attr),
    .isAttrib (isAttrib),
    .pattern  (pattern),
    .inverse  (inverse),
    .rgb      (rgb)
  );

  assign phi2   = (phase == ulaPkg::phCpu); // High in the last third
  assign phi2En = strobes.phiEn;
  assign pixClk = strobes.pixelEn;
  assign hBlank = ~pos.hBlankN;
  assign vBlank = ~pos.vBlankN;

endmodule

/* tb/ulaVideo_chk.sv */
`timescale 1ns/1ns

module ulaVideo_chk (
  input logic                CLK_24,
  input logic                RESET_INT,
  input logic                phi2En,
  input logic                hSyncN,
  input logic                vSyncN,
  input logic [15:0]         memAddr,
  input ulaPkg::seqStrobes_t strobes
);

  localparam int lineClks = 64 * 24;

  int vLowClks; // Clocks spent in vsync

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT)
      vLowClks <= 0;
    else if (!vSyncN)
      vLowClks <= vLowClks + 1;
    else
      vLowClks <= 0;
  end

  // One clock enable per system cycle
  assert property (@(posedge CLK_24) disable iff (RESET_INT) phi2En |=> !phi2En)
    else $error("phi2En wider than one clock");

  assert property (@(posedge CLK_24) disable iff (RESET_INT)
                   (!hSyncN && !vSyncN) |-> vLowClks <= 2 * lineClks)
    else $error("vsync longer than two lines");

  // Address only moves after a fetch strobe
  assert property (@(posedge CLK_24) disable iff (RESET_INT)
                   !$stable(memAddr) |-> $past(strobes.fetch1Latch || strobes.fetch2Latch))
    else $error("memAddr changed outside a fetch slot");

endmodule

bind ulaVideo ulaVideo_chk chk0 (
  .CLK_24    (CLK_24),
  .RESET_INT (RESET_INT),
  .phi2En    (phi2En),
  .hSyncN    (hSyncN),
  .vSyncN    (vSyncN),
  .memAddr   (memAddr),
  .strobes   (strobes)
);

/* tb/ulaVideoTb.sv */
`timescale 1ns/1ns

module ulaVideoTb;

  localparam int lineClks  = 64 * 24;  // One line of system cycles
  localparam int frameClks = 313 * lineClks; // Longest frame, 50 Hz

  logic        CLK_24;
  logic        RESET_INT;
  logic [7:0]  memData = 8'h00;
  logic [15:0] memAddr;
  logic        phi2;
  logic        phi2En;
  logic        pixClk;
  logic [2:0]  rgb;
  logic        hSyncN;
  logic        vSyncN;
  logic        hBlank;
  logic        vBlank;

  logic [7:0] mem [0:65535]; // 64 KB video memory
  int clkCount = 0;
  int syncClk;    // Clock count at the last vsync fall
  int syncLine;   // Line number at that fall
  int frameLines;
  int errorCount = 0;
  int seedVal;

  ulaVideo dut0 (
    .CLK_24    (CLK_24),
    .RESET_INT (RESET_INT),
    .memData   (memData),
    .memAddr   (memAddr),
    .phi2      (phi2),
    .phi2En    (phi2En),
    .pixClk    (pixClk),
    .rgb       (rgb),
    .hSyncN    (hSyncN),
    .vSyncN    (vSyncN),
    .hBlank    (hBlank),
    .vBlank    (vBlank)
  );

  initial begin
    CLK_24 = 1'b0;
    forever #5 CLK_24 = ~CLK_24;
  end

  // Memory answers one clock after the address
  always @(posedge CLK_24) begin
    memData  <= mem[memAddr];
    clkCount <= clkCount + 1;
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic abortRun();
    errorCount++;
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic checkAddr(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkRgb(string name, logic [2:0] got, logic [2:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkCount(string name, int got, int exp);
    if (got != exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun();
    end
  endtask

  //////////////////////////////////////////////////
  // Frame alignment
  //////////////////////////////////////////////////
  task automatic waitVsyncFall();
    logic prevSync;
    prevSync = vSyncN;
    @(negedge CLK_24);
    while (!(prevSync && !vSyncN)) begin
      prevSync = vSyncN;
      @(negedge CLK_24);
    end
  endtask

  // Fall seen in slot 16, first clock of hCount 0
  task automatic markSync(int line, int lines);
    syncClk    = clkCount;
    syncLine   = line;
    frameLines = lines;
  endtask

  task automatic syncFrame(int line, int lines);
    waitVsyncFall();
    markSync(line, lines);
  endtask

  // Off counts clocks from slot 16 of cell (v, h)
  task automatic waitCell(int v, int h, int off);
    int ahead;
    int target;
    ahead  = (v - syncLine + frameLines) % frameLines;
    target = syncClk + (ahead * 64 + h) * 24 + off;
    if (target < clkCount) begin
      $display("Cell on line %0d column %0d was asked for after it went by", v, h);
      abortRun();
    end
    while (clkCount != target)
      @(negedge CLK_24);
  endtask

  task automatic fillRandom();
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'($urandom) | 8'h40; // Bit 6 set, never an attribute
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic testClocks();
    int highClks;
    int enPulses;
    int pixPulses;
    int periodClks;
    logic prevPhi;
    highClks   = 0;
    enPulses   = 0;
    pixPulses  = 0;
    periodClks = 0;
    while (phi2) @(negedge CLK_24);
    while (!phi2) @(negedge CLK_24); // First clock of phi2 high
    do begin
      if (phi2) highClks++;
      if (phi2En) enPulses++;
      if (pixClk) pixPulses++;
      prevPhi = phi2;
      @(negedge CLK_24);
      periodClks++;
    end while (!(!prevPhi && phi2) && periodClks < 100);
    checkCount("phi2 period", periodClks, 24);
    checkCount("phi2 high clocks", highClks, 8);
    checkCount("phi2En pulses", enPulses, 1);
    checkCount("pixClk pulses", pixPulses, 6);
  endtask

  task automatic testSyncTiming();
    int hLow;
    int vLow;
    int hBlankClks;
    int vBlankClks;
    hLow       = 0;
    vLow       = 0;
    hBlankClks = 0;
    vBlankClks = 0;
    repeat (lineClks) begin
      if (!hSyncN) hLow++;
      if (hBlank) hBlankClks++;
      @(negedge CLK_24);
    end
    checkCount("hSyncN low clocks", hLow, 5 * 24);
    checkCount("hBlank clocks", hBlankClks, (64 - 40) * 24); // 40 visible columns
    syncFrame(241, 261);
    while (!vSyncN) begin
      vLow++;
      if (vBlank) vBlankClks++;
      @(negedge CLK_24);
    end
    checkCount("vSyncN low clocks", vLow, 2 * lineClks);
    while (vSyncN) begin // Rest of the frame up to the next fall
      if (vBlank) vBlankClks++;
      @(negedge CLK_24);
    end
    checkCount("60 Hz frame clocks", clkCount - syncClk, 261 * lineClks);
    checkCount("vBlank clocks", vBlankClks, (261 - 224) * lineClks);
  endtask

  task automatic checkTextCell(int v, int h, bit dbl);
    logic [15:0] cellAddr;
    logic [7:0]  screenByte;
    logic [2:0]  charRow;
    cellAddr   = 16'hBB80 + 16'((v / 8) * 40 + h);
    screenByte = mem[cellAddr];
    charRow    = dbl ? 3'((v / 2) % 8) : 3'(v % 8); // Double height halves the row
    waitCell(v, h, 8);
    checkAddr("memAddr", memAddr, cellAddr);
    waitCell(v, h, 16);
    checkAddr("memAddr", memAddr, {6'h2D, screenByte[6:0], charRow});
  endtask

  task automatic testTextFetch();
    fillRandom();
    mem[16'hBB80 + 16'(6 * 40 + 2)] = 8'h0A; // Style, double height, row 6
    syncFrame(241, 261);
    checkTextCell(37, 10, 1'b0);
    checkTextCell(53, 10, 1'b1);
  endtask

  task automatic checkCellColour(int v, int h, logic [2:0] exp);
    waitCell(v, h, 26); // First pixel of the cell
    checkRgb("rgb", rgb, exp);
    waitCell(v, h, 44); // Fifth pixel
    checkRgb("rgb", rgb, exp);
  endtask

  task automatic testColours();
    logic [15:0] rowAddr;
    logic [7:0]  paperAttr;
    paperAttr = 8'h14; // Paper, blue
    rowAddr   = 16'hBB80 + 16'(7 * 40);
    mem[rowAddr + 16'd1] = 8'h41;
    mem[rowAddr + 16'd2] = 8'h42;
    mem[rowAddr + 16'd3] = paperAttr;
    mem[rowAddr + 16'd4] = 8'h41;
    mem[rowAddr + 16'd5] = 8'hC1; // Inverse
    mem[rowAddr + 16'd6] = 8'h42;
    mem[rowAddr + 16'd7] = 8'h01; // Ink, red
    mem[rowAddr + 16'd8] = 8'h42;
    for (int r = 4; r <= 5; r++) begin
      mem[{6'h2D, 7'h41, 3'(r)}] = 8'h40; // Empty pattern
      mem[{6'h2D, 7'h42, 3'(r)}] = 8'h7F; // Full pattern
    end
    syncFrame(241, 261);
    checkCellColour(60, 4, 3'd4);
    checkCellColour(60, 5, 3'd3);
    checkCellColour(60, 6, 3'd7);
    checkCellColour(60, 8, 3'd1);
    checkCellColour(61, 1, 3'd0); // Paper back to black
    checkCellColour(61, 2, 3'd7); // Ink back to white
  endtask

  task automatic testHires();
    mem[16'hBB81] = 8'h1E; // Mode, 50 Hz and hires
    waitVsyncFall();       // Last 60 Hz sync
    syncFrame(258, 313);
    waitVsyncFall();
    checkCount("50 Hz frame clocks", clkCount - syncClk, 313 * lineClks);
    markSync(258, 313);
    waitCell(100, 7, 8);
    checkAddr("memAddr", memAddr, 16'hA000 + 16'(100 * 40 + 7));
    waitCell(210, 7, 8);
    checkAddr("memAddr", memAddr, 16'hBB80 + 16'((210 / 8) * 40 + 7));
  endtask

  initial begin
    RESET_INT = 1'b1;
    seedVal   = $urandom(86);
    for (int a = 0; a < 65536; a++)
      mem[a] = 8'h00;
    repeat (16) @(posedge CLK_24);
    RESET_INT <= 1'b0;
    @(negedge CLK_24);
    testClocks();
    testSyncTiming();
    testTextFetch();
    testColours();
    testHires();
    if (errorCount == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "Checks failed");
    end
  end

  // About seven frames of tests, twelve allowed
  initial begin
    repeat (12 * frameClks) @(posedge CLK_24);
    $display("Watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

/* ulaVideo.f */
src/ulaPkg.sv
src/ulaSequencer.sv
src/videoTiming.sv
src/videoAddrGen.sv
src/attribLatch.sv
src/pixelShifter.sv
src/ulaVideo.sv
tb/ulaVideo_chk.sv
tb/ulaVideoTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the ulaVideo testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -sv --top-module ulaVideoTb -f ulaVideo.f -o simv
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation returned status $simStatus"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "No pass line in log"
  exit 1
fi
exit 0
